//--- src/mac_array_defines.svh
`ifndef MAC_ARRAY_DEFINES_SVH
`define MAC_ARRAY_DEFINES_SVH

// array is N_DIM x N_DIM and N_DIM has to be a multiple of 4 for the 2-bit packing
`define N_DIM 8

`define ACT_W 8
`define WEIGHT_W 8
`define ACC_W 32
`define SHIFT_W 5

`define APB_ADDR_W 8

// bias byte b of row r lives at 4r+b, byte 0 is the least significant
`define ADDR_BIAS_LAST (4 * `N_DIM - 1)
`define ADDR_SHIFT 8'h20
`define ADDR_PREC 8'h21

`endif

//--- src/mac_array_pkg.sv
`include "mac_array_defines.svh"

package mac_array_pkg;

	// value 3 never reaches the datapath, the register block folds it to PREC_8
	typedef enum logic [1:0] {
		PREC_8 = 2'd0,
		PREC_4 = 2'd1,
		PREC_2 = 2'd2
	} out_prec_e;

	// one activation or output byte per lane
	typedef logic [`N_DIM-1:0][`ACT_W-1:0] act_vec_t;

	// one accumulator per row
	typedef logic signed [`N_DIM-1:0][`ACC_W-1:0] acc_vec_t;

	// weight[r][c] multiplies activation c into row r
	typedef logic [`N_DIM-1:0][`N_DIM-1:0][`WEIGHT_W-1:0] weight_mat_t;

endpackage

//--- src/cfg_if.sv
`timescale 1ns/10ps
`include "mac_array_defines.svh"

interface cfg_if;
	import mac_array_pkg::*;

	acc_vec_t bias; // preload value of each row
	logic [`SHIFT_W-1:0] shift;
	out_prec_e out_prec;
	logic prec_written; // pulses for one cycle after a precision write

	modport source (
		output bias,
		output shift,
		output out_prec,
		output prec_written
	);

	modport sink (
		input bias,
		input shift,
		input out_prec,
		input prec_written
	);
endinterface

//--- src/apb_config_regs.sv
`timescale 1ns/10ps
`include "mac_array_defines.svh"

module apb_config_regs (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_W-1:0] paddr,
	input logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic pready,
	output logic pslverr,
	cfg_if.source cfg
);
	import mac_array_pkg::*;

	localparam int BIAS_IDX_W = $clog2(4 * `N_DIM);

	logic [4*`N_DIM-1:0][7:0] bias_bytes; // same bit layout as acc_vec_t
	logic [`SHIFT_W-1:0] shift_q;
	logic [1:0] prec_q;
	logic bias_hit;
	logic shift_hit;
	logic prec_hit;
	logic access;
	logic wr_en;

	assign bias_hit = (paddr <= `ADDR_BIAS_LAST);
	assign shift_hit = (paddr == `ADDR_SHIFT);
	assign prec_hit = (paddr == `ADDR_PREC);

	assign access = psel && penable;
	assign wr_en = access && pwrite;

	assign pready = 1'b1; // no wait states
	assign pslverr = access && !(bias_hit || shift_hit || prec_hit);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			bias_bytes <= '0;
			shift_q <= '0;
			prec_q <= 2'd0;
			cfg.prec_written <= 1'b0;
		end else begin
			cfg.prec_written <= wr_en && prec_hit;
			if (wr_en && bias_hit) begin
				bias_bytes[paddr[BIAS_IDX_W-1:0]] <= pwdata;
			end
			if (wr_en && shift_hit) begin
				shift_q <= pwdata[`SHIFT_W-1:0];
			end
			if (wr_en && prec_hit) begin
				prec_q <= pwdata[1:0];
			end
		end
	end

	always_comb begin
		prdata = 8'h00; // unmapped addresses read as zero
		if (bias_hit) begin
			prdata = bias_bytes[paddr[BIAS_IDX_W-1:0]];
		end else if (shift_hit) begin
			prdata = {{(8 - `SHIFT_W){1'b0}}, shift_q};
		end else if (prec_hit) begin
			prdata = {6'b000000, prec_q};
		end
	end

	assign cfg.bias = bias_bytes;
	assign cfg.shift = shift_q;
	assign cfg.out_prec = (prec_q == 2'd3) ? PREC_8 : out_prec_e'(prec_q);

endmodule

//--- src/dot_product_stage.sv
`timescale 1ns/10ps
`include "mac_array_defines.svh"

module dot_product_stage (
	input logic clk,
	input logic reset,
	input logic beat_valid,
	input logic beat_last,
	input mac_array_pkg::act_vec_t act,
	input mac_array_pkg::weight_mat_t weight,
	output logic row_valid,
	output logic row_last,
	output mac_array_pkg::acc_vec_t row_sum
);

	// heap ordered tree per row, leaves at N_DIM and up, total in node 1
	logic signed [`ACC_W-1:0] node [`N_DIM][1:2*`N_DIM-1];

	always_comb begin
		for (int r = 0; r < `N_DIM; r++) begin
			for (int c = 0; c < `N_DIM; c++) begin
				node[r][`N_DIM + c] = `ACC_W'($signed(act[c]) * $signed(weight[r][c]));
			end
			for (int i = `N_DIM - 1; i > 0; i--) begin
				node[r][i] = node[r][2 * i] + node[r][2 * i + 1];
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			row_valid <= 1'b0;
			row_last <= 1'b0;
		end else begin
			row_valid <= beat_valid;
			row_last <= beat_valid && beat_last;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_valid) begin
			for (int r = 0; r < `N_DIM; r++) begin
				row_sum[r] <= node[r][1];
			end
		end
	end

endmodule

//--- src/accumulate_stage.sv
`timescale 1ns/10ps
`include "mac_array_defines.svh"

module accumulate_stage (
	input logic clk,
	input logic reset,
	input logic row_valid,
	input logic row_last,
	input mac_array_pkg::acc_vec_t row_sum,
	cfg_if.sink cfg,
	output logic acc_valid,
	output mac_array_pkg::acc_vec_t acc
);
	import mac_array_pkg::*;

	typedef enum logic {
		GRP_FIRST,
		GRP_NEXT
	} grp_state_e;

	grp_state_e state;
	acc_vec_t base;
	acc_vec_t total;

	always_comb begin
		base = (state == GRP_FIRST) ? cfg.bias : acc; // the bias enters once per group
		for (int r = 0; r < `N_DIM; r++) begin
			total[r] = base[r] + row_sum[r];
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= GRP_FIRST;
			acc_valid <= 1'b0;
		end else begin
			acc_valid <= row_valid && row_last;
			if (row_valid) begin
				state <= row_last ? GRP_FIRST : GRP_NEXT;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (row_valid) begin
			acc <= total;
		end
	end

endmodule

//--- src/requant_stage.sv
`timescale 1ns/10ps
`include "mac_array_defines.svh"

module requant_stage (
	input logic clk,
	input logic reset,
	input logic acc_valid,
	input mac_array_pkg::acc_vec_t acc,
	cfg_if.sink cfg,
	output logic q_valid,
	output mac_array_pkg::act_vec_t q
);
	import mac_array_pkg::*;

	logic signed [`ACC_W-1:0] sat_max;
	logic signed [`ACC_W-1:0] sat_min;
	logic signed [`ACC_W-1:0] shifted [`N_DIM];
	act_vec_t q_next;

	always_comb begin
		case (cfg.out_prec)
			PREC_4: begin
				sat_max = 7;
				sat_min = -8;
			end
			PREC_2: begin
				sat_max = 1;
				sat_min = -2;
			end
			default: begin
				sat_max = 127; // symmetric range, -128 is never produced
				sat_min = -127;
			end
		endcase
	end

	always_comb begin
		for (int r = 0; r < `N_DIM; r++) begin
			shifted[r] = $signed(acc[r]) >>> cfg.shift;
			if (shifted[r] > sat_max) begin
				q_next[r] = sat_max[`ACT_W-1:0];
			end else if (shifted[r] < sat_min) begin
				q_next[r] = sat_min[`ACT_W-1:0];
			end else begin
				q_next[r] = shifted[r][`ACT_W-1:0]; // in range, so already sign extended
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			q_valid <= 1'b0;
		end else begin
			q_valid <= acc_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (acc_valid) begin
			q <= q_next;
		end
	end

endmodule

//--- src/output_packer.sv
`timescale 1ns/10ps
`include "mac_array_defines.svh"

module output_packer (
	input logic clk,
	input logic reset,
	input logic q_valid,
	input mac_array_pkg::act_vec_t q,
	cfg_if.sink cfg,
	output logic out_valid,
	output mac_array_pkg::act_vec_t out_data
);
	import mac_array_pkg::*;

	localparam int HALF = `N_DIM / 2;
	localparam int QUARTER = `N_DIM / 4;
	localparam int NIB = `ACT_W / 2;

	logic [1:0] count; // vectors already gathered
	act_vec_t gather [3];
	act_vec_t pack4;
	act_vec_t pack2;
	act_vec_t word;
	logic emit;

	// first vector fills the low half, the incoming one the high half
	always_comb begin
		for (int m = 0; m < `N_DIM; m++) begin
			if (m < HALF) begin
				pack4[m] = {gather[0][2*m+1][NIB-1:0], gather[0][2*m][NIB-1:0]};
			end else begin
				pack4[m] = {q[2*m-`N_DIM+1][NIB-1:0], q[2*m-`N_DIM][NIB-1:0]};
			end
		end
	end

	always_comb begin
		int quarter;
		int e;
		act_vec_t src;
		for (int m = 0; m < `N_DIM; m++) begin
			quarter = m / QUARTER;
			e = 4 * (m % QUARTER);
			if (quarter < 3) begin
				src = gather[quarter];
			end else begin
				src = q; // the fourth vector is still on the input
			end
			pack2[m] = {src[e+3][1:0], src[e+2][1:0], src[e+1][1:0], src[e][1:0]};
		end
	end

	always_comb begin
		case (cfg.out_prec)
			PREC_4: begin
				emit = (count == 2'd1);
				word = pack4;
			end
			PREC_2: begin
				emit = (count == 2'd3);
				word = pack2;
			end
			default: begin
				emit = 1'b1;
				word = q;
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count <= 2'd0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= q_valid && emit;
			if (cfg.prec_written) begin
				count <= 2'd0; // a new precision starts a fresh gathering
			end else if (q_valid) begin
				count <= emit ? 2'd0 : count + 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (q_valid && !emit) begin
			gather[count] <= q;
		end
		if (q_valid && emit) begin
			out_data <= word;
		end
	end

endmodule

//--- src/mac_array_top.sv
`timescale 1ns/10ps
`include "mac_array_defines.svh"

module mac_array_top (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_W-1:0] paddr,
	input logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic in_valid,
	input logic in_last,
	input mac_array_pkg::act_vec_t act_in,
	input mac_array_pkg::weight_mat_t weight_in,
	output logic out_valid,
	output mac_array_pkg::act_vec_t out_data
);
	import mac_array_pkg::*;

	logic row_valid;
	logic row_last;
	acc_vec_t row_sum;
	logic acc_valid;
	acc_vec_t acc;
	logic q_valid;
	act_vec_t q;

	cfg_if cfg_bus ();

	apb_config_regs u_regs (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.cfg(cfg_bus.source)
	);

	dot_product_stage u_dot (
		.clk(clk),
		.reset(reset),
		.beat_valid(in_valid),
		.beat_last(in_last),
		.act(act_in),
		.weight(weight_in),
		.row_valid(row_valid),
		.row_last(row_last),
		.row_sum(row_sum)
	);

	accumulate_stage u_acc (
		.clk(clk),
		.reset(reset),
		.row_valid(row_valid),
		.row_last(row_last),
		.row_sum(row_sum),
		.cfg(cfg_bus.sink),
		.acc_valid(acc_valid),
		.acc(acc)
	);

	requant_stage u_requant (
		.clk(clk),
		.reset(reset),
		.acc_valid(acc_valid),
		.acc(acc),
		.cfg(cfg_bus.sink),
		.q_valid(q_valid),
		.q(q)
	);

	output_packer u_packer (
		.clk(clk),
		.reset(reset),
		.q_valid(q_valid),
		.q(q),
		.cfg(cfg_bus.sink),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

//--- tests/result_checker.sv
`timescale 1ns/10ps
`include "mac_array_defines.svh"

module result_checker (
	input logic clk,
	input logic reset,
	input logic out_valid,
	input mac_array_pkg::act_vec_t out_data
);
	import mac_array_pkg::*;

	act_vec_t exp_words [$];
	int unsigned exp_edges [$]; // rising edge at which each word has to be seen
	int unsigned edge_count = 0; // index of the next rising edge
	int test_checks = 0;
	int test_errors = 0;
	int total_checks = 0;
	int total_errors = 0;
	int tests_done = 0;

	function automatic void expect_word(input act_vec_t word, input int unsigned at_edge);
		exp_words.push_back(word);
		exp_edges.push_back(at_edge);
	endfunction

	function automatic int pending();
		return exp_words.size();
	endfunction

	function automatic void compare_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		test_checks++;
		if (actual !== expected) begin
			test_errors++;
			$display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual,
				expected);
		end
	endfunction

	task automatic check_output();
		act_vec_t want;
		int unsigned want_edge;
		test_checks++;
		if (exp_words.size() == 0) begin
			test_errors++;
			$display("at %0t the DUT produced word 0x%016h when no output was due", $time,
				out_data);
		end else begin
			want = exp_words.pop_front();
			want_edge = exp_edges.pop_front();
			if (out_data !== want) begin
				test_errors++;
				$display("** Error at %0t: output word 0x%016h, expected 0x%016h", $time,
					out_data, want);
			end
			if (edge_count != want_edge) begin
				test_errors++;
				$display("** Error at %0t: output seen on cycle %0d, expected on cycle %0d",
					$time, edge_count, want_edge);
			end
		end
	endtask

	always @(posedge clk) begin
		edge_count <= edge_count + 1;
		if (reset && out_valid) begin
			check_output();
		end
	end

	function automatic void end_test(input string name);
		if (exp_words.size() != 0) begin
			test_errors++;
			$display("%0d expected output words never arrived during %s", exp_words.size(),
				name);
			exp_words.delete();
			exp_edges.delete();
		end
		tests_done++;
		$display("test %0d, %s: %0d checks, %0d errors", tests_done, name, test_checks,
			test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		test_checks = 0;
		test_errors = 0;
	endfunction

	function automatic void report_totals();
		$display("%0d tests, %0d checks, %0d errors", tests_done, total_checks, total_errors);
	endfunction

endmodule

//--- tests/tb_mac_array.sv
`timescale 1ns/10ps
`include "mac_array_defines.svh"

module tb_mac_array;
	import mac_array_pkg::*;

	localparam int N = `N_DIM;
	localparam int NREGS = 4 * N + 2; // bias bytes, shift and precision
	localparam int APB_CYCLES = 2;
	localparam int DRAIN_CYCLES = 8;
	localparam int CFG_CYCLES = NREGS * APB_CYCLES + DRAIN_CYCLES;
	localparam int MAX_GAP = 2;
	localparam int T2_GROUPS = 40;
	localparam int T3_GROUPS = 24;
	localparam int T4_PAIRS = 16;
	localparam int T5_SETS = 4;
	localparam int T1_CYCLES = (4 * NREGS + 2) * APB_CYCLES;
	localparam int T2_CYCLES = CFG_CYCLES + T2_GROUPS * (1 + MAX_GAP) + DRAIN_CYCLES;
	localparam int T3_CYCLES = CFG_CYCLES + T3_GROUPS * 5 * (1 + MAX_GAP) + DRAIN_CYCLES;
	localparam int T4_CYCLES = CFG_CYCLES + T4_PAIRS * 2 * 3 * 2 + DRAIN_CYCLES;
	localparam int T5_CYCLES = 3 * CFG_CYCLES + (T5_SETS * 4 + 2) * 2 * 2;
	localparam int TIMEOUT_CYCLES = 2 * (4 + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
		+ T5_CYCLES);

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_W-1:0] paddr;
	logic [7:0] pwdata;
	logic [7:0] prdata;
	logic pready;
	logic pslverr;
	logic in_valid;
	logic in_last;
	act_vec_t act_in;
	weight_mat_t weight_in;
	logic out_valid;
	act_vec_t out_data;

	int seed = 89218;
	int cycle_count = 0;
	logic [7:0] shadow [NREGS]; // register contents the DUT should hold
	logic [N*`ACT_W-1:0] pack_bits; // output word being gathered by the model
	int pack_count;

	mac_array_top dut (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.in_valid(in_valid),
		.in_last(in_last),
		.act_in(act_in),
		.weight_in(weight_in),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	result_checker u_checker (
		.clk(clk),
		.reset(reset),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [7:0] rand_small();
		return 8'($random(seed) % 16); // -15..15
	endfunction

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic int shadow_idx(input logic [7:0] addr);
		if (addr <= `ADDR_BIAS_LAST) begin
			return int'(addr);
		end
		if (addr == `ADDR_SHIFT) begin
			return 4 * N;
		end
		if (addr == `ADDR_PREC) begin
			return 4 * N + 1;
		end
		return -1;
	endfunction

	function automatic logic [7:0] reg_addr(input int i);
		return (i < 4 * N) ? 8'(i) : 8'(`ADDR_SHIFT + i - 4 * N);
	endfunction

	function automatic logic [31:0] bias_of(input int r);
		return {shadow[4*r+3], shadow[4*r+2], shadow[4*r+1], shadow[4*r]};
	endfunction

	function automatic int prec_bits();
		case (shadow[4*N+1][1:0])
			2'd1: return 4;
			2'd2: return 2;
			default: return 8; // 3 behaves like 8 bits
		endcase
	endfunction

	function automatic logic [7:0] requant(input logic signed [31:0] total);
		logic signed [31:0] v;
		int hi;
		int lo;
		hi = (1 << (prec_bits() - 1)) - 1;
		lo = (prec_bits() == 8) ? -hi : -hi - 1; // the 8-bit range is symmetric
		v = total >>> shadow[4*N][`SHIFT_W-1:0];
		if (v > hi) begin
			v = hi;
		end else if (v < lo) begin
			v = lo;
		end
		return v[7:0];
	endfunction

	// fields fill the word from bit 0 upward in arrival order
	task automatic record_result(input logic signed [31:0] totals [N], input int unsigned s_edge);
		logic [7:0] lane;
		int bits;
		bits = prec_bits();
		for (int e = 0; e < N; e++) begin
			lane = requant(totals[e]);
			for (int b = 0; b < bits; b++) begin
				pack_bits[(pack_count * N + e) * bits + b] = lane[b];
			end
		end
		pack_count++;
		if (pack_count == `ACT_W / bits) begin
			u_checker.expect_word(pack_bits, s_edge + 4); // seen 4 rising edges after the beat
			pack_count = 0;
			pack_bits = '0;
		end
	endtask

	task automatic apb_transfer(input logic write, input logic [7:0] addr,
			input logic [7:0] wdata, output logic [7:0] rdata, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		rdata = prdata; // the bus is still held here so the responses have settled
		err = pslverr;
		u_checker.compare_value($sformatf("pready at 0x%02h", addr), 32'(pready),
			32'd1);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		logic [7:0] rdata;
		logic err;
		int idx;
		idx = shadow_idx(addr);
		apb_transfer(1'b1, addr, data, rdata, err);
		u_checker.compare_value($sformatf("pslverr of write 0x%02h", addr), 32'(err),
			32'(idx < 0));
		if (idx == 4 * N) begin
			shadow[idx] = {{(8 - `SHIFT_W){1'b0}}, data[`SHIFT_W-1:0]};
		end else if (idx == 4 * N + 1) begin
			shadow[idx] = {6'b000000, data[1:0]};
			pack_count = 0; // the packer starts over after a precision write
			pack_bits = '0;
		end else if (idx >= 0) begin
			shadow[idx] = data;
		end
	endtask

	task automatic check_reg(input logic [7:0] addr);
		logic [7:0] rdata;
		logic err;
		logic [7:0] want;
		int idx;
		idx = shadow_idx(addr);
		want = 8'h00;
		if (idx >= 0) begin
			want = shadow[idx];
		end
		apb_transfer(1'b0, addr, 8'h00, rdata, err);
		u_checker.compare_value($sformatf("read of 0x%02h", addr), 32'(rdata), 32'(want));
		u_checker.compare_value($sformatf("pslverr of read 0x%02h", addr), 32'(err),
			32'(idx < 0));
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < NREGS; i++) begin
			check_reg(reg_addr(i));
		end
	endtask

	task automatic set_biases(input int range, input logic big);
		logic [31:0] b;
		for (int r = 0; r < N; r++) begin
			b = 32'($random(seed) % range);
			if (big && rand_below(2) != 0) begin
				b = b + ((rand_below(2) != 0) ? 32'h0010_0000 : 32'hFFF0_0000);
			end
			for (int k = 0; k < 4; k++) begin
				write_reg(8'(4 * r + k), b[8*k +: 8]);
			end
		end
	endtask

	task automatic send_group(input int beats, input int max_gap);
		logic signed [31:0] sums [N];
		int unsigned s_edge;
		for (int r = 0; r < N; r++) begin
			sums[r] = bias_of(r); // bias enters once per group
		end
		for (int k = 0; k < beats; k++) begin
			for (int c = 0; c < N; c++) begin
				act_in[c] = rand_small();
			end
			for (int r = 0; r < N; r++) begin
				for (int c = 0; c < N; c++) begin
					weight_in[r][c] = rand_small();
					sums[r] = sums[r] + int'($signed(act_in[c])) * int'($signed(weight_in[r][c]));
				end
			end
			in_valid = 1'b1;
			in_last = (k == beats - 1);
			s_edge = u_checker.edge_count; // the next rising edge samples this beat
			@(negedge clk);
			in_valid = 1'b0;
			in_last = 1'b0;
			if (k == beats - 1) begin
				record_result(sums, s_edge);
			end
			repeat (rand_below(max_gap + 1)) @(negedge clk);
		end
	endtask

	task automatic wait_drain();
		repeat (6) @(negedge clk); // longer than the pipeline
		while (u_checker.pending() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic reset_and_register_test();
		u_checker.compare_value("out_valid after reset", 32'(out_valid), 32'd0);
		check_all_regs();
		for (int i = 0; i < 4 * N; i++) begin
			if (rand_below(2) != 0) begin
				write_reg(reg_addr(i), 8'($random(seed)));
			end
		end
		write_reg(`ADDR_SHIFT, 8'($random(seed)));
		write_reg(`ADDR_PREC, 8'($random(seed)));
		check_all_regs();
		write_reg(8'h25, 8'($random(seed))); // an unmapped address must be ignored
		check_reg(8'h25);
		check_all_regs();
		u_checker.end_test("reset and register access");
	endtask

	task automatic prec8_single_beat_test();
		wait_drain();
		set_biases(2000, 1'b0);
		write_reg(`ADDR_SHIFT, 8'(rand_below(5)));
		write_reg(`ADDR_PREC, 8'd0);
		for (int g = 0; g < T2_GROUPS; g++) begin
			send_group(1, MAX_GAP);
		end
		wait_drain();
		u_checker.end_test("8-bit single beat groups");
	endtask

	task automatic multi_beat_test();
		wait_drain();
		set_biases(3000, 1'b0);
		write_reg(`ADDR_SHIFT, 8'(2 + rand_below(4)));
		write_reg(`ADDR_PREC, 8'd0);
		for (int g = 0; g < T3_GROUPS; g++) begin
			send_group(1 + rand_below(5), MAX_GAP);
		end
		wait_drain();
		u_checker.end_test("multi beat groups with gaps");
	endtask

	task automatic prec4_pair_test();
		wait_drain();
		set_biases(500, 1'b0);
		write_reg(`ADDR_SHIFT, 8'(3 + rand_below(3)));
		write_reg(`ADDR_PREC, 8'd1);
		for (int g = 0; g < 2 * T4_PAIRS; g++) begin
			send_group(1 + rand_below(3), 1);
		end
		wait_drain();
		u_checker.end_test("4-bit packed pairs");
	endtask

	task automatic prec2_set_test();
		wait_drain();
		set_biases(200, 1'b1);
		write_reg(`ADDR_SHIFT, 8'(7 + rand_below(3)));
		write_reg(`ADDR_PREC, 8'd2);
		for (int s = 0; s < T5_SETS; s++) begin
			if (s == 2) begin
				send_group(1, 1); // half a set that the precision write then drops
				send_group(2, 1);
				wait_drain();
				write_reg(`ADDR_PREC, 8'd2);
			end
			for (int g = 0; g < 4; g++) begin
				send_group(1 + rand_below(2), 1);
			end
		end
		wait_drain();
		u_checker.end_test("2-bit packed sets");
	endtask

	initial begin
		for (int i = 0; i < NREGS; i++) begin
			shadow[i] = 8'h00;
		end
		pack_bits = '0;
		pack_count = 0;
		reset = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = 8'h00;
		in_valid = 1'b0;
		in_last = 1'b0;
		act_in = '0;
		weight_in = '0;
		repeat (4) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		reset_and_register_test();
		prec8_single_beat_test();
		multi_beat_test();
		prec4_pair_test();
		prec2_set_test();
		u_checker.report_totals();
		if (u_checker.total_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+src
src/mac_array_pkg.sv
src/cfg_if.sv
src/apb_config_regs.sv
src/dot_product_stage.sv
src/accumulate_stage.sv
src/requant_stage.sv
src/output_packer.sv
src/mac_array_top.sv
tests/result_checker.sv
tests/tb_mac_array.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_mac_array -f project.f -o tb_mac_array

output=$(./obj_dir/tb_mac_array)
echo "$output"

if grep -q "TEST RESULT: PASS" <<< "$output"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
